// File: Bender.yml
package:
  name: rvcore

sources:
  - files:
      - design/rvPkg.sv
      - design/mainControl.sv
      - design/aluControl.sv
      - design/alu.sv
      - design/regFile.sv
      - design/immGen.sv
      - design/pcUnit.sv
      - design/rvCore.sv
  - target: simulation
    files:
      - verif/tbClock.sv
      - verif/rvCoreTb.sv

// File: compile.f
design/rvPkg.sv
design/mainControl.sv
design/aluControl.sv
design/alu.sv
design/regFile.sv
design/immGen.sv
design/pcUnit.sv
design/rvCore.sv
verif/tbClock.sv
verif/rvCoreTb.sv

// File: design/alu.sv
module alu import rvPkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOpT           aluOp,
    input  brCondT          brCond,
    output logic [xlen-1:0] result,
    output logic            cmpTrue
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;
    logic       isEqual;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;
    assign isEqual    = a == b;

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $signed(a) >>> shamt;
            aluSlt:   result = {{(xlen-1){1'b0}}, ltSigned};
            aluSltu:  result = {{(xlen-1){1'b0}}, ltUnsigned};
            aluPassB: result = b;
            default:  result = a + b;
        endcase
    end

    // Branch decision
    always_comb begin
        case (brCond)
            brEq:    cmpTrue = isEqual;
            brNe:    cmpTrue = !isEqual;
            brLt:    cmpTrue = ltSigned;
            brGe:    cmpTrue = !ltSigned;
            brLtu:   cmpTrue = ltUnsigned;
            brGeu:   cmpTrue = !ltUnsigned;
            default: cmpTrue = 1'b0;
        endcase
    end

endmodule

// File: design/aluControl.sv
module aluControl import rvPkg::*; (
    input  aluClassT   aluClass,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    output aluOpT      aluOp,
    output brCondT     brCond
);

    logic subSel;

    // Only register ops use bit 30 to pick sub
    assign subSel = (aluClass == clsReg) && funct7b5;

    always_comb begin
        aluOp  = aluAdd;
        brCond = brEq;

        case (aluClass)
            clsBranch: begin
                aluOp = aluSub;
                case (funct3)
                    3'b000:  brCond = brEq;
                    3'b001:  brCond = brNe;
                    3'b100:  brCond = brLt;
                    3'b101:  brCond = brGe;
                    3'b110:  brCond = brLtu;
                    3'b111:  brCond = brGeu;
                    default: brCond = brEq;
                endcase
            end
            clsReg, clsImm: begin
                case (funct3)
                    3'b000:  aluOp = subSel ? aluSub : aluAdd;
                    3'b001:  aluOp = aluSll;
                    3'b010:  aluOp = aluSlt;
                    3'b011:  aluOp = aluSltu;
                    3'b100:  aluOp = aluXor;
                    3'b101:  aluOp = funct7b5 ? aluSra : aluSrl;  // srai uses it too
                    3'b110:  aluOp = aluOr;
                    default: aluOp = aluAnd;
                endcase
            end
            default: aluOp = aluAdd;  // clsAdd
        endcase
    end

endmodule

// File: design/immGen.sv
module immGen import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] imm
);

    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immJ;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Layout follows the opcode
    always_comb begin
        case (opcodeT'(instr[6:0]))
            opLoad, opOpImm, opJalr: imm = immI;
            opStore:                 imm = immS;
            opBranch:                imm = immB;
            opLui, opAuipc:          imm = immU;
            opJal:                   imm = immJ;
            default:                 imm = '0;
        endcase
    end

endmodule

// File: design/mainControl.sv
module mainControl import rvPkg::*; (
    input  logic [6:0] opcode,
    output logic       branch,
    output logic       jump,
    output logic       jalr,
    output logic       memRead,
    output logic       memWrite,
    output logic       aluSrc,
    output logic       regWrite,
    output wbSelT      wbSel,
    output aBaseT      aBase,
    output aluClassT   aluClass
);

    always_comb begin
        // Unknown opcodes fall through as a no-op
        branch   = 1'b0;
        jump     = 1'b0;
        jalr     = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        wbSel    = wbAlu;
        aBase    = aRs1;
        aluClass = clsAdd;

        case (opcodeT'(opcode))
            opOp: begin
                regWrite = 1'b1;
                aluClass = clsReg;
            end
            opOpImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluClass = clsImm;
            end
            opLoad: begin
                memRead  = 1'b1;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                wbSel    = wbMem;
            end
            opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            opBranch: begin
                branch   = 1'b1;
                aluClass = clsBranch;
            end
            opLui: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aBase    = aZero;  // 0 + U-imm
            end
            opAuipc: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aBase    = aPc;
            end
            opJal: begin
                jump     = 1'b1;
                regWrite = 1'b1;
                wbSel    = wbPcPlus4;
            end
            opJalr: begin
                jalr     = 1'b1;
                regWrite = 1'b1;
                aluSrc   = 1'b1;  // Target is rs1 + I-imm
                wbSel    = wbPcPlus4;
            end
            default: ;
        endcase
    end

endmodule

// File: design/pcUnit.sv
module pcUnit import rvPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    input  logic            run,
    input  logic            branch,
    input  logic            jump,
    input  logic            jalr,
    input  logic            cmpTrue,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] aluResult,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pcPlus4
);

    logic [xlen-1:0] pcNext;
    logic [xlen-1:0] pcTarget;

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;  // Branch and jal share this adder

    always_comb begin
        if (jalr) begin
            pcNext = {aluResult[xlen-1:1], 1'b0};
        end else if (jump || (branch && cmpTrue)) begin
            pcNext = pcTarget;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else if (run) begin
            pc <= pcNext;
        end
    end

    pcAligned: assert property (
        @(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00
    );

endmodule

// File: design/regFile.sv
module regFile import rvPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rs1Addr,
    input  logic [regAddrW-1:0] rs2Addr,
    input  logic [regAddrW-1:0] rdAddr,
    input  logic [xlen-1:0]     rdData,
    input  logic                we,
    output logic [xlen-1:0]     rs1Data,
    output logic [xlen-1:0]     rs2Data
);

    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rdAddr != '0) begin  // x0 never written
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    // x0 must still read zero after any write sequence
    x0ReadsZero: assert property (
        @(posedge clk) disable iff (!arstN)
        (rs1Addr == '0 |-> rs1Data == '0) and (rs2Addr == '0 |-> rs2Data == '0)
    );

endmodule

// File: design/rvCore.sv
module rvCore import rvPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    output logic [xlen-1:0] imemAddr,
    input  logic [xlen-1:0] imemData,
    output logic [xlen-1:0] dmemAddr,
    output logic [xlen-1:0] dmemWdata,
    output logic            dmemWe,
    output logic            dmemRe,
    input  logic [xlen-1:0] dmemRdata
);

    logic                run;
    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     pcPlus4;
    logic [regAddrW-1:0] rs1Addr;
    logic [regAddrW-1:0] rs2Addr;
    logic [regAddrW-1:0] rdAddr;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [xlen-1:0]     rdData;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     aluA;
    logic [xlen-1:0]     aluB;
    logic [xlen-1:0]     aluResult;
    logic                cmpTrue;

    logic     branch;
    logic     jump;
    logic     jalr;
    logic     memRead;
    logic     memWrite;
    logic     aluSrc;
    logic     regWrite;
    wbSelT    wbSel;
    aBaseT    aBase;
    aluClassT aluClass;
    aluOpT    aluOp;
    brCondT   brCond;

    // Goes high one edge after reset release
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    assign imemAddr = pc;
    assign rs1Addr  = imemData[19:15];
    assign rs2Addr  = imemData[24:20];
    assign rdAddr   = imemData[11:7];

    mainControl uMainControl (
        .opcode(imemData[6:0]), .branch, .jump, .jalr, .memRead, .memWrite,
        .aluSrc, .regWrite, .wbSel, .aBase, .aluClass
    );

    aluControl uAluControl (
        .aluClass, .funct3(imemData[14:12]), .funct7b5(imemData[30]), .aluOp, .brCond
    );

    immGen uImmGen (.instr(imemData), .imm);

    regFile uRegFile (
        .clk, .arstN, .rs1Addr, .rs2Addr, .rdAddr, .rdData,
        .we(regWrite && run), .rs1Data, .rs2Data
    );

    always_comb begin
        case (aBase)
            aPc:     aluA = pc;
            aZero:   aluA = '0;
            default: aluA = rs1Data;
        endcase
    end

    assign aluB = aluSrc ? imm : rs2Data;

    alu uAlu (.a(aluA), .b(aluB), .aluOp, .brCond, .result(aluResult), .cmpTrue);

    pcUnit uPcUnit (
        .clk, .arstN, .run, .branch, .jump, .jalr, .cmpTrue, .imm, .aluResult,
        .pc, .pcPlus4
    );

    always_comb begin
        case (wbSel)
            wbMem:     rdData = dmemRdata;
            wbPcPlus4: rdData = pcPlus4;  // Link address
            default:   rdData = aluResult;
        endcase
    end

    assign dmemAddr  = aluResult;
    assign dmemWdata = rs2Data;
    assign dmemWe    = memWrite && run;
    assign dmemRe    = memRead && run;

endmodule

// File: design/rvPkg.sv
package rvPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    localparam logic [xlen-1:0] resetPc = '0;

    // Major opcode field in instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opOpImm  = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSll   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluSlt   = 4'd8,
        aluSltu  = 4'd9,
        aluPassB = 4'd10
    } aluOpT;

    // How aluControl reads funct3
    typedef enum logic [1:0] {
        clsAdd    = 2'd0,  // Address arithmetic
        clsBranch = 2'd1,
        clsReg    = 2'd2,
        clsImm    = 2'd3
    } aluClassT;

    typedef enum logic [2:0] {
        brEq  = 3'd0,
        brNe  = 3'd1,
        brLt  = 3'd2,
        brGe  = 3'd3,
        brLtu = 3'd4,
        brGeu = 3'd5
    } brCondT;

    // Write-back source
    typedef enum logic [1:0] {
        wbAlu     = 2'd0,
        wbMem     = 2'd1,
        wbPcPlus4 = 2'd2
    } wbSelT;

    // ALU operand A source
    typedef enum logic [1:0] {
        aPc   = 2'd0,  // auipc
        aZero = 2'd1,  // lui
        aRs1  = 2'd2
    } aBaseT;

endpackage

// File: verif/rvCoreTb.sv
module rvCoreTb import rvPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cycleLimit = 6 * (4 + 64) * 2;

    logic            clk;
    logic            arstN;
    logic [xlen-1:0] imemAddr;
    logic [xlen-1:0] imemData;
    logic [xlen-1:0] dmemAddr;
    logic [xlen-1:0] dmemWdata;
    logic            dmemWe;
    logic            dmemRe;
    logic [xlen-1:0] dmemRdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] wrAddr [$];
    logic [31:0] wrData [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];

    int seed = 32'hb9e04629;
    int errors = 0;
    int startErrs;
    int pcIdx;
    int relCnt = 0;  // Edges seen since reset release
    int cycles;

    tbClock clkGen (.clk, .arstN);

    rvCore uut (
        .clk, .arstN, .imemAddr, .imemData, .dmemAddr, .dmemWdata, .dmemWe, .dmemRe,
        .dmemRdata
    );

    assign imemData  = imem[imemAddr[7:2]];
    assign dmemRdata = dmem[dmemAddr[9:2]];

    function automatic logic [31:0] rType(opcodeT op, logic [4:0] rd, logic [2:0] f3,
                                          logic [4:0] rs1, logic [4:0] rs2, logic alt);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iType(opcodeT op, logic [4:0] rd, logic [2:0] f3,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};  // sw
    endfunction

    function automatic logic [31:0] bType(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] uType(opcodeT op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // RV32I result for an OP or OP-IMM funct3
    function automatic logic [31:0] refAlu(logic [2:0] f3, logic alt, logic [31:0] x,
                                           logic [31:0] y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return {31'b0, $signed(x) < $signed(y)};
            3'd3:    return {31'b0, x < y};
            3'd4:    return x ^ y;
            3'd5: begin
                if (alt) return $signed(x) >>> y[4:0];
                else return x >> y[4:0];
            end
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic refBranch(logic [2:0] f3, logic [31:0] x, logic [31:0] y);
        case (f3)
            3'd0:    return x == y;
            3'd1:    return x != y;
            3'd4:    return $signed(x) < $signed(y);
            3'd5:    return $signed(x) >= $signed(y);
            3'd6:    return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expV,
                              input logic [31:0] gotV);
        assert (gotV === expV) else begin
            $display("error %s expected 0x%h got 0x%h", name, expV, gotV);
            errors++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[pcIdx] = word;
        pcIdx++;
    endtask

    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;  // Undo the addi sign extension
        emit(uType(opLui, rd, hi[31:12]));
        emit(iType(opOpImm, rd, 3'b000, rd, value[11:0]));
    endtask

    task automatic store(input logic [4:0] rs2, input logic [11:0] offset);
        emit(sType(rs2, 5'd0, offset));
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic fillMemories();
        for (int i = 0; i < 64; i++) begin
            imem[i] = {i[24:0], 7'b1111111};  // Unknown opcode tagged with its index
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h5a5a_0000 ^ (i << 2);
        end
    endtask

    task automatic startTest();
        clkGen.holdReset();
        fillMemories();
        wrAddr.delete();
        wrData.delete();
        expAddr.delete();
        expData.delete();
        pcIdx     = 0;
        startErrs = errors;
    endtask

    task automatic finishTest(input string name);
        int n;
        clkGen.releaseReset();
        for (int i = 0; i < 64 && wrAddr.size() < expAddr.size(); i++) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);  // Catch stray stores
        n = wrAddr.size();
        for (int k = 0; k < expAddr.size(); k++) begin
            assert (k < n) else begin
                $display("store %0d to address 0x%h never happened", k, expAddr[k]);
                errors++;
            end
            if (k < n) begin
                checkValue("dmemAddr", expAddr[k], wrAddr[k]);
                checkValue("dmemWdata", expData[k], wrData[k]);
            end
        end
        assert (n <= expAddr.size()) else begin
            $display("%0d stores seen where only %0d belong", n, expAddr.size());
            errors++;
        end
        $display("%s: %0d errors", name, errors - startErrs);
    endtask

    // Memory write port and strobe checks
    always @(posedge clk) begin
        if (!arstN) begin
            relCnt = 0;
        end
        if (relCnt == 0) begin
            checkValue("dmemWe", 32'd0, {31'b0, dmemWe});
        end
        if (arstN && relCnt == 0) begin
            checkValue("imemAddr", 32'd0, imemAddr);
        end
        if (relCnt > 0) begin
            checkValue("dmemRe", {31'b0, imemData[6:0] == opLoad}, {31'b0, dmemRe});
        end
        if (dmemWe) begin
            dmem[dmemAddr[9:2]] = dmemWdata;
            wrAddr.push_back(dmemAddr);
            wrData.push_back(dmemWdata);
        end
        if (arstN) begin
            relCnt++;
        end
    end

    task automatic aluTest();
        logic [2:0]  f3Tab [10];
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic        alt;
        int          slot;
        f3Tab = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        a = $random(seed);
        b = $random(seed);
        startTest();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        slot = 0;
        for (int k = 0; k < 10; k++) begin
            alt = (k == 1) || (k == 7);  // sub and sra
            emit(rType(opOp, 5'd3, f3Tab[k], 5'd1, 5'd2, alt));
            store(5'd3, 12'(4 * slot));
            expectStore(4 * slot, refAlu(f3Tab[k], alt, a, b));
            slot++;
            if (k != 1) begin
                imm = 12'($random(seed));
                if (f3Tab[k] == 3'd1 || f3Tab[k] == 3'd5) begin
                    imm = {1'b0, alt, 5'b0, imm[4:0]};
                end
                emit(iType(opOpImm, 5'd3, f3Tab[k], 5'd1, imm));
                store(5'd3, 12'(4 * slot));
                expectStore(4 * slot, refAlu(f3Tab[k], alt, a, {{20{imm[11]}}, imm}));
                slot++;
            end
        end
        emit(jType(5'd0, 21'd0));
        finishTest("alu");
    endtask

    task automatic memTest();
        logic [31:0] val;
        logic [31:0] pre;
        logic [11:0] addrA;
        startTest();
        pre       = $random(seed);
        dmem[200] = pre;  // Word at 0x320
        for (int k = 0; k < 3; k++) begin
            val   = $random(seed);
            addrA = {4'b0, 6'($random(seed)), 2'b0};
            loadConst(5'd1, val);
            store(5'd1, addrA);
            emit(iType(opLoad, 5'd2, 3'b010, 5'd0, addrA));
            store(5'd2, addrA + 12'd256);
            expectStore({20'b0, addrA}, val);
            expectStore({20'b0, addrA} + 32'd256, val);
        end
        emit(iType(opLoad, 5'd3, 3'b010, 5'd0, 12'd800));
        store(5'd3, 12'd1020);
        expectStore(32'd1020, pre);
        emit(jType(5'd0, 21'd0));
        finishTest("memory");
    endtask

    task automatic branchTest();
        logic [2:0]  condTab [6];
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        swap;
        logic        same;
        logic        taken;
        condTab = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        a = $random(seed) | 32'h8000_0000;  // Negative and large as unsigned
        b = $random(seed) & 32'h7fff_ffff;
        startTest();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        emit(iType(opOpImm, 5'd5, 3'b000, 5'd0, 12'd1));  // Fall-through marker
        emit(iType(opOpImm, 5'd6, 3'b000, 5'd0, 12'd2));  // Taken marker
        for (int k = 0; k < 12; k++) begin
            f3    = condTab[k / 2];
            swap  = k[0] && f3[2];
            same  = k[0] && !f3[2];  // Equal operands for beq and bne
            taken = refBranch(f3, swap ? b : a, (swap || same) ? a : b);
            emit(bType(f3, swap ? 5'd2 : 5'd1, (swap || same) ? 5'd1 : 5'd2, 13'd12));
            store(5'd5, 12'(4 * k));
            emit(jType(5'd0, 21'd8));
            store(5'd6, 12'(4 * k));
            expectStore(4 * k, taken ? 32'd2 : 32'd1);
        end
        emit(jType(5'd0, 21'd0));
        finishTest("branch");
    endtask

    task automatic jumpTest();
        logic [19:0] u1;
        logic [19:0] u2;
        logic [31:0] at;
        logic [31:0] tgt;
        u1 = 20'($random(seed));
        u2 = 20'($random(seed));
        startTest();
        emit(uType(opLui, 5'd1, u1));
        store(5'd1, 12'd0);
        expectStore(32'd0, {u1, 12'b0});
        at = 32'(pcIdx * 4);
        emit(uType(opAuipc, 5'd2, u2));
        store(5'd2, 12'd4);
        expectStore(32'd4, at + {u2, 12'b0});
        at = 32'(pcIdx * 4);
        emit(jType(5'd3, 21'd12));
        store(5'd0, 12'd8);  // Skipped by jal
        store(5'd0, 12'd8);
        store(5'd3, 12'd8);
        expectStore(32'd8, at + 32'd4);
        tgt = 32'((pcIdx + 4) * 4);
        emit(iType(opOpImm, 5'd4, 3'b000, 5'd0, 12'(tgt - 32'd3)));
        at = 32'(pcIdx * 4);
        emit(iType(opJalr, 5'd5, 3'b000, 5'd4, 12'd4));  // Odd target sum loses bit 0
        store(5'd0, 12'd12);
        store(5'd0, 12'd12);
        store(5'd5, 12'd12);
        expectStore(32'd12, at + 32'd4);
        emit(jType(5'd0, 21'd0));
        finishTest("jump");
    endtask

    task automatic x0Test();
        logic [31:0] val;
        val = $random(seed);
        startTest();
        loadConst(5'd1, val);
        emit(iType(opOpImm, 5'd0, 3'b000, 5'd1, 12'h7ff));
        emit(rType(opOp, 5'd0, 3'b000, 5'd1, 5'd1, 1'b0));
        emit(uType(opLui, 5'd0, 20'habcde));
        store(5'd0, 12'd0);
        expectStore(32'd0, 32'd0);
        emit({12'h010, 5'd1, 3'b000, 5'd1, 7'b0001011});     // Unknown opcode shaped like addi
        emit({7'd0, 5'd1, 5'd0, 3'b010, 5'd8, 7'b1011011});  // Unknown opcode shaped like sw
        store(5'd1, 12'd4);
        expectStore(32'd4, val);
        emit(jType(5'd0, 21'd0));
        finishTest("x0");
    endtask

    task automatic resetTest();
        startTest();
        store(5'd0, 12'd0);  // Sits at the reset fetch address
        emit(jType(5'd0, 21'd0));
        expectStore(32'd0, 32'd0);
        finishTest("reset");
    endtask

    initial begin
        for (cycles = 0; cycles < cycleLimit; cycles++) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles, run stopped", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        fillMemories();
        aluTest();
        memTest();
        branchTest();
        jumpTest();
        x0Test();
        resetTest();
        $display("%0d tests finished, %0d errors", 6, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/tbClock.sv
module tbClock (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk   = 1'b0;
        arstN = 1'b0;
    end

    always #4 clk = ~clk;  // 8 ns period

    // Reset changes on the falling edge
    task automatic holdReset();
        @(negedge clk);
        arstN = 1'b0;
    endtask

    task automatic releaseReset();
        repeat (4) @(negedge clk);
        arstN = 1'b1;
    endtask

endmodule
